//--- Makefile
# Verilator flow for the serial program loader

VERILATOR  ?= verilator
TOP        := tb_uart_loader
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert --Mdir $(OBJ_DIR)
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the run prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int DIV = `UART_TICK_DIV;
    localparam int CW  = $clog2(DIV);
    localparam logic [CW-1:0] C_LAST = CW'(DIV - 1);

    // Free running divider
    logic [CW-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            // One tick per wrap
            tick <= (cnt == C_LAST);
            if (cnt == C_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        tx_start,
    input  logic        rx,
    input  logic [31:0] uart_data,
    output logic        mips_enable,
    output logic        tx,
    output logic        write,
    output logic        tx_dataready,
    output logic [31:0] rx_address,
    output logic [31:0] dout
);

    logic       tick;
    logic       rx_done;
    logic [7:0] rx_byte;
    logic       byte_start;
    logic [7:0] byte_data;
    logic       byte_done;

    // 16x tick shared by both directions
    baud_gen u_baud (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    ////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////
    uart_rx u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .tick    (tick),
        .rx_done (rx_done),
        .rx_byte (rx_byte)
    );

    word_assembler u_asm (
        .clk         (clk),
        .rst         (rst),
        .rx_done     (rx_done),
        .rx_byte     (rx_byte),
        .write       (write),
        .address     (rx_address),
        .data        (dout),
        .mips_enable (mips_enable)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////
    // Echo of each written word, or a result from the core
    word_serializer u_ser (
        .clk          (clk),
        .rst          (rst),
        .echo_start   (write),
        .echo_word    (dout),
        .host_start   (tx_start),
        .host_word    (uart_data),
        .byte_done    (byte_done),
        .byte_start   (byte_start),
        .byte_data    (byte_data),
        .tx_dataready (tx_dataready)
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .byte_done  (byte_done),
        .tx         (tx)
    );

endmodule

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // One 32-bit word, seen whole or as four byte lanes
    // Lane 0 is the least significant byte
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  lanes;
    } uart_word_u;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

endpackage

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    input  logic       tick,
    output logic       rx_done,
    output logic [7:0] rx_byte
);

    localparam int OS = `UART_OVERSAMPLE;
    localparam int SW = $clog2(OS);
    // Mid-bit from the start edge, then one full bit per sample
    localparam logic [SW-1:0] S_MID  = SW'(OS / 2 - 1);
    localparam logic [SW-1:0] S_LAST = SW'(OS - 1);

    logic [1:0]          rx_sync;
    logic                rx_s;
    uart_pkg::rx_state_e state;
    logic [SW-1:0]       s_cnt;
    logic [2:0]          n_bits;
    logic [7:0]          shift;

    // Two-flop synchronizer, idle line is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    assign rx_s = rx_sync[1];

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= uart_pkg::rx_idle;
            s_cnt   <= '0;
            n_bits  <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                uart_pkg::rx_idle: begin
                    // Falling edge starts a frame
                    if (!rx_s) begin
                        state <= uart_pkg::rx_start;
                        s_cnt <= '0;
                    end
                end
                uart_pkg::rx_start: begin
                    if (tick) begin
                        if (s_cnt == S_MID) begin
                            // Glitch if line is back high at mid-bit
                            state  <= rx_s ? uart_pkg::rx_idle : uart_pkg::rx_data;
                            s_cnt  <= '0;
                            n_bits <= '0;
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::rx_data: begin
                    if (tick) begin
                        if (s_cnt == S_LAST) begin
                            s_cnt <= '0;
                            if (n_bits == 3'd7) begin
                                state <= uart_pkg::rx_stop;
                            end else begin
                                n_bits <= n_bits + 1'b1;
                            end
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // Stop bit, done at its middle
                    if (tick) begin
                        if (s_cnt == S_LAST) begin
                            state   <= uart_pkg::rx_idle;
                            rx_done <= 1'b1;
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Data bits, LSB first, shifted in from the top
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_data && tick && s_cnt == S_LAST) begin
            shift <= {rx_s, shift[7:1]};
        end
    end

    assign rx_byte = shift;

    // Done is a single-cycle strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) rx_done |=> !rx_done);

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       byte_start,
    input  logic [7:0] byte_data,
    output logic       byte_done,
    output logic       tx
);

    localparam int OS = `UART_OVERSAMPLE;
    localparam int SW = $clog2(OS);
    localparam logic [SW-1:0] S_LAST = SW'(OS - 1);

    uart_pkg::tx_state_e state;
    logic [SW-1:0]       s_cnt;
    logic [2:0]          n_bits;
    logic [7:0]          shift;

    ////////////////////////////////////////////////////////////
    // Frame FSM, line driven from a flop
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= uart_pkg::tx_idle;
            s_cnt     <= '0;
            n_bits    <= '0;
            byte_done <= 1'b0;
            tx        <= 1'b1;
        end else begin
            byte_done <= 1'b0;
            case (state)
                uart_pkg::tx_idle: begin
                    if (byte_start) begin
                        // Start bit goes out right away
                        state <= uart_pkg::tx_start;
                        s_cnt <= '0;
                        tx    <= 1'b0;
                    end
                end
                uart_pkg::tx_start: begin
                    if (tick) begin
                        if (s_cnt == S_LAST) begin
                            state  <= uart_pkg::tx_data;
                            s_cnt  <= '0;
                            n_bits <= '0;
                            tx     <= shift[0];
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::tx_data: begin
                    if (tick) begin
                        if (s_cnt == S_LAST) begin
                            s_cnt <= '0;
                            if (n_bits == 3'd7) begin
                                state <= uart_pkg::tx_stop;
                                tx    <= 1'b1;
                            end else begin
                                n_bits <= n_bits + 1'b1;
                                // Next bit before the shift lands
                                tx     <= shift[1];
                            end
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // Full stop bit, then done
                    if (tick) begin
                        if (s_cnt == S_LAST) begin
                            state     <= uart_pkg::tx_idle;
                            byte_done <= 1'b1;
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Byte register, loaded on start, LSB out first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::tx_idle && byte_start) begin
            shift <= byte_data;
        end else if (state == uart_pkg::tx_data && tick && s_cnt == S_LAST) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    // Serializer must wait for byte_done
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        byte_start |-> state == uart_pkg::tx_idle);

endmodule

`default_nettype wire

//--- hw/word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module word_assembler (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_done,
    input  logic [7:0]  rx_byte,
    output logic        write,
    output logic [31:0] address,
    output logic [31:0] data,
    output logic        mips_enable
);

    uart_pkg::uart_word_u word_q;
    uart_pkg::uart_word_u word_next;
    logic [1:0]           idx;
    logic                 take;

    // Loading stops for good after the end marker
    assign take = rx_done && !mips_enable;

    // Word as it stands once the incoming byte is placed
    always_comb begin
        word_next            = word_q;
        word_next.lanes[idx] = rx_byte;
    end

    ////////////////////////////////////////////////////////////
    // Byte lanes, LSB first
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (take) begin
            word_q <= word_next;
        end
    end

    assign data = word_q.word;

    // Lane index, write strobe, address and run flag
    always_ff @(posedge clk) begin
        if (rst) begin
            idx         <= '0;
            write       <= 1'b0;
            address     <= '0;
            mips_enable <= 1'b0;
        end else begin
            write <= 1'b0;
            // Next slot once the previous word is out
            if (write) begin
                address <= address + 32'd4;
            end
            if (take) begin
                idx <= idx + 1'b1;
                if (idx == 2'd3) begin
                    if (word_next.word == `UART_END_WORD) begin
                        mips_enable <= 1'b1;
                    end else begin
                        write <= 1'b1;
                    end
                end
            end
        end
    end

    // Program memory is word addressed in steps of four
    a_addr_align: assert property (@(posedge clk) disable iff (rst) address[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_serializer (
    input  logic        clk,
    input  logic        rst,
    input  logic        echo_start,
    input  logic [31:0] echo_word,
    input  logic        host_start,
    input  logic [31:0] host_word,
    input  logic        byte_done,
    output logic        byte_start,
    output logic [7:0]  byte_data,
    output logic        tx_dataready
);

    uart_pkg::uart_word_u word_q;
    logic [1:0]           lane;
    logic                 busy;
    logic                 accept;

    // Only taken when idle, requests while busy are lost
    assign accept = !busy && (echo_start || host_start);

    ////////////////////////////////////////////////////////////
    // Word capture, echo before host
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            if (echo_start) begin
                word_q.word <= echo_word;
            end else begin
                word_q.word <= host_word;
            end
        end
    end

    // Lane under transmission, steady while byte_start is high
    assign byte_data = word_q.lanes[lane];

    ////////////////////////////////////////////////////////////
    // Lane sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            lane         <= '0;
            byte_start   <= 1'b0;
            tx_dataready <= 1'b0;
        end else begin
            byte_start   <= 1'b0;
            tx_dataready <= 1'b0;
            if (accept) begin
                // First byte on the next clock
                busy       <= 1'b1;
                lane       <= '0;
                byte_start <= 1'b1;
            end else if (busy && byte_done) begin
                if (lane == 2'd3) begin
                    // Last stop bit sent
                    busy         <= 1'b0;
                    tx_dataready <= 1'b1;
                end else begin
                    lane       <= lane + 1'b1;
                    byte_start <= 1'b1;
                end
            end
        end
    end

    // A new byte is never launched on the word's last done
    a_start_vs_ready: assert property (@(posedge clk) disable iff (rst)
        !(byte_start && tx_dataready));

endmodule

`default_nettype wire

//--- include/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////////////////////////////////////////////
// Line timing
////////////////////////////////////////////////////////////

// System clock in Hz
`define UART_CLK_FREQ 10_000_000

// Serial line rate
`define UART_BAUD 156_250

// Ticks per bit on both directions
`define UART_OVERSAMPLE 16

// Clock cycles per oversampling tick, 4 here, so 64 clocks per bit
`define UART_TICK_DIV (`UART_CLK_FREQ / (`UART_BAUD * `UART_OVERSAMPLE))

////////////////////////////////////////////////////////////
// Loader protocol
////////////////////////////////////////////////////////////

// Word that ends program loading
`define UART_END_WORD 32'hFFFF_FFFF

`endif

//--- project.f
+incdir+include
hw/uart_pkg.sv
hw/baud_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/word_assembler.sv
hw/word_serializer.sv
hw/uart_loader_top.sv
tests/tb_uart_loader.sv

//--- tests/tb_uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_config.svh"

module tb_uart_loader;

    // Clocks per serial bit (64)
    localparam int BIT_CLKS   = `UART_TICK_DIV * `UART_OVERSAMPLE;
    // Four full frames plus margin
    localparam int WORD_WAIT  = 50 * BIT_CLKS;
    localparam int BYTE_WAIT  = 4 * BIT_CLKS;
    localparam int READY_WAIT = 2 * BIT_CLKS;

    logic        clk;
    logic        rst;
    logic        tx_start;
    logic        rx;
    logic [31:0] uart_data;
    logic        mips_enable;
    logic        tx;
    logic        write;
    logic        tx_dataready;
    logic [31:0] rx_address;
    logic [31:0] dout;

    int seed         = 32'hc862f014;
    int errors       = 0;
    int checks       = 0;
    int write_count  = 0;
    int tx_low_count = 0;
    int ready_count  = 0;

    uart_loader_top DUT (
        .clk          (clk),
        .rst          (rst),
        .tx_start     (tx_start),
        .rx           (rx),
        .uart_data    (uart_data),
        .mips_enable  (mips_enable),
        .tx           (tx),
        .write        (write),
        .tx_dataready (tx_dataready),
        .rx_address   (rx_address),
        .dout         (dout)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Activity counters see the values from before each edge
    always @(posedge clk) begin
        if (write) write_count++;
        if (!tx) tx_low_count++;
        if (tx_dataready) ready_count++;
    end

    ////////////////////////////////////////////////////////////
    // Checking and line helpers
    ////////////////////////////////////////////////////////////
    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        errors++;
    endtask

    task automatic apply_reset;
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // One 8N1 frame on rx with the LSB first
    task automatic send_byte(input logic [7:0] b);
        int i;
        rx = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = 1'b1;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic send_word(input logic [31:0] w);
        int k;
        for (k = 0; k < 4; k++) begin
            send_byte(w[8*k +: 8]);
        end
    endtask

    // Finds a start bit on tx, then samples every bit at its middle
    task automatic recv_byte(input string name, output logic [7:0] b, output logic ok);
        int n;
        int i;
        ok = 1'b0;
        b  = '0;
        n  = 0;
        while (tx !== 1'b0 && n < BYTE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            report_timeout({"a start bit on tx in ", name});
            return;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            $display("Start bit on tx went high before mid-bit in %s", name);
            errors++;
            return;
        end
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (tx !== 1'b1) begin
            $display("Stop bit on tx was low in %s", name);
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic wait_write_pulse(input string name, output logic found);
        int n;
        n = 0;
        while (write !== 1'b1 && n < WORD_WAIT) begin
            @(negedge clk);
            n++;
        end
        found = (write === 1'b1);
        if (!found) report_timeout({"a write pulse in ", name});
    endtask

    task automatic catch_dataready(input string name);
        int n;
        n = 0;
        while (tx_dataready !== 1'b1 && n < READY_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (tx_dataready !== 1'b1) begin
            report_timeout({"tx_dataready in ", name});
        end else begin
            @(negedge clk);
        end
    endtask

    // Echo bytes arrive LSB first
    task automatic expect_four_bytes(input string name, input logic [31:0] w);
        logic [7:0] b;
        logic       ok;
        int         k;
        ok = 1'b1;
        for (k = 0; k < 4 && ok; k++) begin
            recv_byte(name, b, ok);
            if (ok) compare({name, " tx byte"}, {24'd0, w[8*k +: 8]}, {24'd0, b});
        end
        if (ok) catch_dataready(name);
    endtask

    // Write pulse lands mid stop bit and is watched while sending
    task automatic load_and_echo(input string name, input logic [31:0] w,
                                 input logic [31:0] addr);
        logic found;
        fork
            send_word(w);
            begin
                wait_write_pulse(name, found);
                if (found) begin
                    compare({name, " dout"}, w, dout);
                    compare({name, " rx_address"}, addr, rx_address);
                    expect_four_bytes(name, w);
                end
            end
        join
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic idle_after_reset;
        int n;
        for (n = 0; n < 200; n++) begin
            @(negedge clk);
            compare("reset state", 32'h8, {28'd0, tx, write, mips_enable, tx_dataready});
        end
    endtask

    task automatic load_three_words;
        load_and_echo("load word 0", 32'h1234_5678, 32'd0);
        load_and_echo("load word 1", 32'hDEAD_BEEF, 32'd4);
        load_and_echo("load word 2", 32'hA5C3_0F81, 32'd8);
    endtask

    task automatic end_marker_stops_loading;
        int writes_before;
        int lows_before;
        int ready_before;
        int n;
        writes_before = write_count;
        lows_before   = tx_low_count;
        ready_before  = ready_count;
        send_word(`UART_END_WORD);
        n = 0;
        while (mips_enable !== 1'b1 && n < READY_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (mips_enable !== 1'b1) report_timeout("mips_enable after the end marker");
        // Long enough for a whole echo to finish
        repeat (45 * BIT_CLKS) @(negedge clk);
        compare("end marker writes", 32'(writes_before), 32'(write_count));
        compare("end marker tx activity", 32'(lows_before), 32'(tx_low_count));
        compare("end marker tx_dataready", 32'(ready_before), 32'(ready_count));
        // Loading is closed for good
        send_word(32'h0BAD_F00D);
        repeat (2 * BIT_CLKS) @(negedge clk);
        compare("word after end marker writes", 32'(writes_before), 32'(write_count));
        compare("word after end marker mips_enable", 32'd1, {31'd0, mips_enable});
    endtask

    task automatic host_result_send;
        logic [31:0] w;
        w = $random(seed);
        compare("host send mips_enable", 32'd1, {31'd0, mips_enable});
        uart_data = w;
        tx_start  = 1'b1;
        @(negedge clk);
        tx_start  = 1'b0;
        expect_four_bytes("host send", w);
    endtask

    task automatic random_program_load;
        logic [31:0] w;
        int          i;
        apply_reset;
        for (i = 0; i < 8; i++) begin
            w = $random(seed);
            // End marker would stop the load
            while (w == `UART_END_WORD) w = $random(seed);
            load_and_echo($sformatf("random word %0d", i), w, 32'(4 * i));
        end
    endtask

    initial begin
        rst       = 1'b1;
        tx_start  = 1'b0;
        rx        = 1'b1;
        uart_data = '0;
        apply_reset;
        idle_after_reset;
        load_three_words;
        end_marker_stops_loading;
        host_result_send;
        random_program_load;
        $display("Checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
